//--- common/tcdm_pkg.sv
/* Sizes and types shared by every TCDM port in the subsystem.
   Word addressing only; byte lanes are selected through the byte enables. */

package tcdm_pkg;

  // Number of initiator ports on the arbiter.
  localparam int unsigned N_INIT = 2;

  // Word address width, 256 words.
  localparam int unsigned ADDR_W = 8;

  // Data word width.
  localparam int unsigned DATA_W = 32;

  // One enable per byte lane.
  localparam int unsigned BE_W = DATA_W / 8;

  // Id wide enough to name each initiator port.
  localparam int unsigned ID_W = 1;

  // Word address.
  typedef logic [ADDR_W-1:0] tcdm_addr_t;

  // Data word.
  typedef logic [DATA_W-1:0] tcdm_data_t;

  // Byte enables.
  typedef logic [BE_W-1:0] tcdm_be_t;

  // Initiator index carried with a request.
  typedef logic [ID_W-1:0] tcdm_id_t;

endpackage : tcdm_pkg

//--- hdl/tcdm_rr_arbiter.sv
/* Two-port round-robin TCDM arbiter. The target must return the id of each read as
   r_id; responses cannot be stalled, so initiators must always accept them. */
`timescale 1ns/1ps

module tcdm_rr_arbiter
  import tcdm_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clear_i,
  // Initiator 0.
  input  logic       init0_req_i,
  input  logic       init0_wen_i,
  input  tcdm_addr_t init0_add_i,
  input  tcdm_data_t init0_data_i,
  input  tcdm_be_t   init0_be_i,
  output logic       init0_gnt_o,
  output logic       init0_r_valid_o,
  output tcdm_data_t init0_r_data_o,
  // Initiator 1.
  input  logic       init1_req_i,
  input  logic       init1_wen_i,
  input  tcdm_addr_t init1_add_i,
  input  tcdm_data_t init1_data_i,
  input  tcdm_be_t   init1_be_i,
  output logic       init1_gnt_o,
  output logic       init1_r_valid_o,
  output tcdm_data_t init1_r_data_o,
  // Shared target side.
  output logic       mem_req_o,
  output logic       mem_wen_o,
  output tcdm_addr_t mem_add_o,
  output tcdm_data_t mem_data_o,
  output tcdm_be_t   mem_be_o,
  output tcdm_id_t   mem_id_o,
  input  logic       mem_gnt_i,
  input  logic       mem_r_valid_i,
  input  tcdm_data_t mem_r_data_i,
  input  tcdm_id_t   mem_r_id_i
);

  // One request bit per initiator.
  logic [N_INIT-1:0] req_vec;
  logic [N_INIT-1:0] gnt_vec;
  // Port favoured on the next conflict.
  logic              prio_q;
  // Index of the winning port.
  logic              sel;
  logic              conflict;

  assign req_vec  = {init1_req_i, init0_req_i};
  assign conflict = &req_vec;

  // Priority only matters when both ports request.
  // A lone requester wins outright.
  always_comb begin
    if (conflict) begin
      sel = prio_q;
    end else begin
      sel = req_vec[1];
    end
  end

  // Forward the winner's request fields.
  assign mem_req_o  = |req_vec;
  assign mem_wen_o  = sel ? init1_wen_i  : init0_wen_i;
  assign mem_add_o  = sel ? init1_add_i  : init0_add_i;
  assign mem_data_o = sel ? init1_data_i : init0_data_i;
  assign mem_be_o   = sel ? init1_be_i   : init0_be_i;

  // Stamp the winning index as id.
  assign mem_id_o = tcdm_id_t'(sel);

  // Target grant goes back to the winner only.
  always_comb begin
    gnt_vec      = '0;
    gnt_vec[sel] = mem_gnt_i & req_vec[sel];
  end

  assign init0_gnt_o = gnt_vec[0];
  assign init1_gnt_o = gnt_vec[1];

  // Move priority away from a port granted under conflict.
  // Without conflict the pointer stays put.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_q <= 1'b0;
    end else if (clear_i) begin
      prio_q <= 1'b0;
    end else if (conflict && mem_gnt_i) begin
      prio_q <= ~sel;
    end
  end

  // Response goes to the port named by r_id.
  assign init0_r_valid_o = mem_r_valid_i && (mem_r_id_i == tcdm_id_t'(1'b0));
  assign init1_r_valid_o = mem_r_valid_i && (mem_r_id_i == tcdm_id_t'(1'b1));

  // Data is shared; r_valid qualifies it per port.
  assign init0_r_data_o = mem_r_data_i;
  assign init1_r_data_o = mem_r_data_i;

endmodule : tcdm_rr_arbiter

//--- hdl/tcdm_r_id_filter.sv
/* Holds the request id for exactly one cycle and returns it as r_id. Valid only where
   the target answers every granted read in the next cycle. */
`timescale 1ns/1ps

module tcdm_r_id_filter
  import tcdm_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clear_i,
  // Target side, toward the arbiter.
  input  logic       tgt_req_i,
  input  logic       tgt_wen_i,
  input  tcdm_addr_t tgt_add_i,
  input  tcdm_data_t tgt_data_i,
  input  tcdm_be_t   tgt_be_i,
  input  tcdm_id_t   tgt_id_i,
  output logic       tgt_gnt_o,
  output logic       tgt_r_valid_o,
  output tcdm_data_t tgt_r_data_o,
  output tcdm_id_t   tgt_r_id_o,
  // Initiator side, toward the bank.
  output logic       ini_req_o,
  output logic       ini_wen_o,
  output tcdm_addr_t ini_add_o,
  output tcdm_data_t ini_data_o,
  output tcdm_be_t   ini_be_o,
  output tcdm_id_t   ini_id_o,
  input  logic       ini_gnt_i,
  input  logic       ini_r_valid_i,
  input  tcdm_data_t ini_r_data_i
);

  // Id of the last granted request.
  tcdm_id_t id_q;

  // Request fields pass straight through.
  assign ini_req_o  = tgt_req_i;
  assign ini_wen_o  = tgt_wen_i;
  assign ini_add_o  = tgt_add_i;
  assign ini_data_o = tgt_data_i;
  assign ini_be_o   = tgt_be_i;
  // Bank never sees the id.
  assign ini_id_o   = '0;

  // Handshake and response data are untouched.
  assign tgt_gnt_o     = ini_gnt_i;
  assign tgt_r_valid_o = ini_r_valid_i;
  assign tgt_r_data_o  = ini_r_data_i;
  assign tgt_r_id_o    = id_q;

  // Capture at the grant edge.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_q <= '0;
    end else if (clear_i) begin
      id_q <= '0;
    end else if (tgt_req_i && ini_gnt_i) begin
      id_q <= tgt_id_i;
    end
  end

endmodule : tcdm_r_id_filter

//--- hdl/tcdm_sram_bank.sv
/* Single-ported 256-word bank; grants every request, read latency of one cycle.
   Contents are undefined after reset; wen high is a read. */
`timescale 1ns/1ps

module tcdm_sram_bank
  import tcdm_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clear_i,
  input  logic       req_i,
  input  logic       wen_i,
  input  tcdm_addr_t add_i,
  input  tcdm_data_t data_i,
  input  tcdm_be_t   be_i,
  output logic       gnt_o,
  output logic       r_valid_o,
  output tcdm_data_t r_data_o
);

  // Word storage.
  tcdm_data_t mem_q [2**ADDR_W];
  tcdm_data_t r_data_q;
  logic       r_valid_q;

  // No wait states.
  assign gnt_o = req_i;

  // Write enabled lanes, or register the read word.
  always_ff @(posedge clk_i) begin
    if (req_i && !wen_i) begin
      for (int b = 0; b < BE_W; b++) begin
        if (be_i[b]) begin
          mem_q[add_i][b*(DATA_W/BE_W) +: DATA_W/BE_W] <=
            data_i[b*(DATA_W/BE_W) +: DATA_W/BE_W];
        end
      end
    end else if (req_i && wen_i) begin
      r_data_q <= mem_q[add_i];
    end
  end

  // One-cycle read strobe.
  // A clear drops a pending response.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else if (clear_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= req_i & wen_i;
    end
  end

  assign r_valid_o = r_valid_q;
  assign r_data_o  = r_data_q;

endmodule : tcdm_sram_bank

//--- hdl/tcdm_subsystem.sv
/* Two initiators sharing one TCDM bank. Initiators must always accept a response;
   write requests return no response. */
`timescale 1ns/1ps

module tcdm_subsystem
  import tcdm_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clear_i,
  input  logic       init0_req_i,
  input  logic       init0_wen_i,
  input  tcdm_addr_t init0_add_i,
  input  tcdm_data_t init0_data_i,
  input  tcdm_be_t   init0_be_i,
  output logic       init0_gnt_o,
  output logic       init0_r_valid_o,
  output tcdm_data_t init0_r_data_o,
  input  logic       init1_req_i,
  input  logic       init1_wen_i,
  input  tcdm_addr_t init1_add_i,
  input  tcdm_data_t init1_data_i,
  input  tcdm_be_t   init1_be_i,
  output logic       init1_gnt_o,
  output logic       init1_r_valid_o,
  output tcdm_data_t init1_r_data_o
);

  // Arbiter to filter.
  logic       arb_req;
  logic       arb_wen;
  tcdm_addr_t arb_add;
  tcdm_data_t arb_data;
  tcdm_be_t   arb_be;
  tcdm_id_t   arb_id;
  logic       arb_gnt;
  logic       arb_r_valid;
  tcdm_data_t arb_r_data;
  tcdm_id_t   arb_r_id;

  // Filter to bank.
  logic       bank_req;
  logic       bank_wen;
  tcdm_addr_t bank_add;
  tcdm_data_t bank_data;
  tcdm_be_t   bank_be;
  logic       bank_gnt;
  logic       bank_r_valid;
  tcdm_data_t bank_r_data;

  tcdm_rr_arbiter u_arbiter (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .clear_i         (clear_i),
    .init0_req_i     (init0_req_i),
    .init0_wen_i     (init0_wen_i),
    .init0_add_i     (init0_add_i),
    .init0_data_i    (init0_data_i),
    .init0_be_i      (init0_be_i),
    .init0_gnt_o     (init0_gnt_o),
    .init0_r_valid_o (init0_r_valid_o),
    .init0_r_data_o  (init0_r_data_o),
    .init1_req_i     (init1_req_i),
    .init1_wen_i     (init1_wen_i),
    .init1_add_i     (init1_add_i),
    .init1_data_i    (init1_data_i),
    .init1_be_i      (init1_be_i),
    .init1_gnt_o     (init1_gnt_o),
    .init1_r_valid_o (init1_r_valid_o),
    .init1_r_data_o  (init1_r_data_o),
    .mem_req_o       (arb_req),
    .mem_wen_o       (arb_wen),
    .mem_add_o       (arb_add),
    .mem_data_o      (arb_data),
    .mem_be_o        (arb_be),
    .mem_id_o        (arb_id),
    .mem_gnt_i       (arb_gnt),
    .mem_r_valid_i   (arb_r_valid),
    .mem_r_data_i    (arb_r_data),
    .mem_r_id_i      (arb_r_id)
  );

  // Sits at the one-cycle latency boundary.
  // Bank has no id port, so the zeroed id ends here.
  tcdm_r_id_filter u_filter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .tgt_req_i     (arb_req),
    .tgt_wen_i     (arb_wen),
    .tgt_add_i     (arb_add),
    .tgt_data_i    (arb_data),
    .tgt_be_i      (arb_be),
    .tgt_id_i      (arb_id),
    .tgt_gnt_o     (arb_gnt),
    .tgt_r_valid_o (arb_r_valid),
    .tgt_r_data_o  (arb_r_data),
    .tgt_r_id_o    (arb_r_id),
    .ini_req_o     (bank_req),
    .ini_wen_o     (bank_wen),
    .ini_add_o     (bank_add),
    .ini_data_o    (bank_data),
    .ini_be_o      (bank_be),
    .ini_id_o      (),
    .ini_gnt_i     (bank_gnt),
    .ini_r_valid_i (bank_r_valid),
    .ini_r_data_i  (bank_r_data)
  );

  tcdm_sram_bank u_bank (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .clear_i   (clear_i),
    .req_i     (bank_req),
    .wen_i     (bank_wen),
    .add_i     (bank_add),
    .data_i    (bank_data),
    .be_i      (bank_be),
    .gnt_o     (bank_gnt),
    .r_valid_o (bank_r_valid),
    .r_data_o  (bank_r_data)
  );

endmodule : tcdm_subsystem

//--- bench/tcdm_protocol_checker.sv
/* Grant and response timing checks, bound to the subsystem top level.
   Assumes the bank answers every granted read in the next cycle. */
`timescale 1ns/1ps

module tcdm_protocol_checker
  import tcdm_pkg::*;
(
  input logic clk_i,
  input logic rst_ni,
  input logic clear_i,
  input logic init0_req_i,
  input logic init0_wen_i,
  input logic init0_gnt_o,
  input logic init0_r_valid_o,
  input logic init1_req_i,
  input logic init1_wen_i,
  input logic init1_gnt_o,
  input logic init1_r_valid_o
);

  // A read granted outside a clear answers in the next cycle.
  a_resp0: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (init0_gnt_o && init0_wen_i && !clear_i) |=> init0_r_valid_o)
    else $error("port 0 read granted without a response one cycle later");
  a_resp1: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (init1_gnt_o && init1_wen_i && !clear_i) |=> init1_r_valid_o)
    else $error("port 1 read granted without a response one cycle later");

  // No response without a granted read.
  a_spur0: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(init0_gnt_o && init0_wen_i && !clear_i) |=> !init0_r_valid_o)
    else $error("port 0 response without a granted read");
  a_spur1: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(init1_gnt_o && init1_wen_i && !clear_i) |=> !init1_r_valid_o)
    else $error("port 1 response without a granted read");

  // Grants follow requests.
  a_gnt0: assert property (@(posedge clk_i) disable iff (!rst_ni) init0_gnt_o |-> init0_req_i)
    else $error("port 0 granted without a request");
  a_gnt1: assert property (@(posedge clk_i) disable iff (!rst_ni) init1_gnt_o |-> init1_req_i)
    else $error("port 1 granted without a request");

endmodule : tcdm_protocol_checker

//--- bench/tb_tcdm_subsystem.sv
/* Table-driven testbench for the two-port TCDM subsystem. Bank words are read only
   after a full write, since the bank content is not reset. */
`timescale 1ns/1ps

module tb_tcdm_subsystem
  import tcdm_pkg::*;
();

  localparam int N_STEPS     = 12;
  localparam int GNT_TIMEOUT = 8;

  // One step: clear pulse, then per port request, read, address and byte enables,
  // then the port expected to win the first cycle of the step.
  typedef struct packed {
    logic       clr;
    logic       req0;
    logic       rd0;
    tcdm_addr_t add0;
    tcdm_be_t   be0;
    logic       req1;
    logic       rd1;
    tcdm_addr_t add1;
    tcdm_be_t   be1;
    logic       win;
  } step_t;

  localparam step_t STEPS [N_STEPS] = '{
    '{1'b0, 1'b1, 1'b0, 8'h10, 4'hf, 1'b0, 1'b0, 8'h00, 4'h0, 1'b0}, // Fill from port 0.
    '{1'b0, 1'b0, 1'b0, 8'h00, 4'h0, 1'b1, 1'b0, 8'h20, 4'hf, 1'b1}, // Fill from port 1.
    '{1'b0, 1'b1, 1'b0, 8'h11, 4'hf, 1'b1, 1'b0, 8'h21, 4'hf, 1'b0}, // First conflict.
    '{1'b0, 1'b1, 1'b0, 8'h10, 4'h5, 1'b0, 1'b0, 8'h00, 4'h0, 1'b0}, // Partial write.
    '{1'b0, 1'b1, 1'b1, 8'h10, 4'hf, 1'b1, 1'b1, 8'h20, 4'hf, 1'b1}, // Merged word read back.
    '{1'b0, 1'b1, 1'b1, 8'h11, 4'hf, 1'b1, 1'b1, 8'h21, 4'hf, 1'b0},
    '{1'b0, 1'b1, 1'b1, 8'h20, 4'hf, 1'b1, 1'b0, 8'h21, 4'h8, 1'b1},
    '{1'b0, 1'b0, 1'b0, 8'h00, 4'h0, 1'b1, 1'b1, 8'h21, 4'hf, 1'b1},
    '{1'b0, 1'b1, 1'b1, 8'h10, 4'hf, 1'b1, 1'b1, 8'h11, 4'hf, 1'b0}, // Leaves priority at 1.
    '{1'b1, 1'b1, 1'b1, 8'h10, 4'hf, 1'b0, 1'b0, 8'h00, 4'h0, 1'b0}, // Read dropped by clear.
    '{1'b0, 1'b1, 1'b1, 8'h20, 4'hf, 1'b1, 1'b1, 8'h21, 4'hf, 1'b0}, // Port 0 wins again.
    '{1'b0, 1'b1, 1'b1, 8'h30, 4'hf, 1'b1, 1'b0, 8'h30, 4'hf, 1'b1}  // Read after write.
  };

  logic       clk_i;
  logic       rst_ni;
  logic       clear_i;
  logic       init0_req_i;
  logic       init0_wen_i;
  tcdm_addr_t init0_add_i;
  tcdm_data_t init0_data_i;
  tcdm_be_t   init0_be_i;
  logic       init0_gnt_o;
  logic       init0_r_valid_o;
  tcdm_data_t init0_r_data_o;
  logic       init1_req_i;
  logic       init1_wen_i;
  tcdm_addr_t init1_add_i;
  tcdm_data_t init1_data_i;
  tcdm_be_t   init1_be_i;
  logic       init1_gnt_o;
  logic       init1_r_valid_o;
  tcdm_data_t init1_r_data_o;

  // Reference model state.
  tcdm_data_t ref_mem [2**ADDR_W];
  logic       exp_rv0;
  logic       exp_rv1;
  tcdm_data_t exp_rd0;
  tcdm_data_t exp_rd1;
  logic [31:0] rng;

  tcdm_subsystem u_dut (.*);

  bind tcdm_subsystem tcdm_protocol_checker u_checker (.*);

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic check_flag(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, act, exp));
    end
  endtask

  task automatic check_data(input string name, input tcdm_data_t act, input tcdm_data_t exp);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, act, exp));
    end
  endtask

  task automatic idle_inputs();
    clear_i      = 1'b0;
    init0_req_i  = 1'b0;
    init0_wen_i  = 1'b0;
    init0_add_i  = '0;
    init0_data_i = '0;
    init0_be_i   = '0;
    init1_req_i  = 1'b0;
    init1_wen_i  = 1'b0;
    init1_add_i  = '0;
    init1_data_i = '0;
    init1_be_i   = '0;
  endtask

  // Runs mid-cycle, once inputs and combinational grants have settled.
  // The expected winner is given by the caller.
  task automatic check_cycle(input logic win);
    tcdm_addr_t win_add;
    tcdm_data_t win_data;
    tcdm_be_t   win_be;
    int         b;
    // Responses owed by last cycle's grant.
    check_flag("init0_r_valid_o", init0_r_valid_o, exp_rv0);
    check_flag("init1_r_valid_o", init1_r_valid_o, exp_rv1);
    if (exp_rv0) begin
      check_data("init0_r_data_o", init0_r_data_o, exp_rd0);
    end
    if (exp_rv1) begin
      check_data("init1_r_data_o", init1_r_data_o, exp_rd1);
    end
    check_flag("init0_gnt_o", init0_gnt_o, init0_req_i && !win);
    check_flag("init1_gnt_o", init1_gnt_o, init1_req_i && win);
    win_add  = win ? init1_add_i : init0_add_i;
    win_data = win ? init1_data_i : init0_data_i;
    win_be   = win ? init1_be_i : init0_be_i;
    exp_rv0  = 1'b0;
    exp_rv1  = 1'b0;
    if (init0_req_i || init1_req_i) begin
      if (win ? init1_wen_i : init0_wen_i) begin
        // A clear cancels the response.
        exp_rv0 = !win && !clear_i;
        exp_rv1 = win && !clear_i;
        exp_rd0 = ref_mem[win_add];
        exp_rd1 = ref_mem[win_add];
      end else begin
        for (b = 0; b < int'(BE_W); b++) begin
          if (win_be[b]) begin
            ref_mem[win_add][8*b +: 8] = win_data[8*b +: 8];
          end
        end
      end
    end
  endtask

  // Drive one table step and hold each request until its grant.
  task automatic apply_step(input int s);
    logic g0;
    logic g1;
    logic done;
    int   waited;
    @(posedge clk_i);
    #1;
    clear_i      = STEPS[s].clr;
    init0_req_i  = STEPS[s].req0;
    init0_wen_i  = STEPS[s].rd0;
    init0_add_i  = STEPS[s].add0;
    init0_be_i   = STEPS[s].be0;
    rng          = xorshift(rng);
    init0_data_i = rng;
    init1_req_i  = STEPS[s].req1;
    init1_wen_i  = STEPS[s].rd1;
    init1_add_i  = STEPS[s].add1;
    init1_be_i   = STEPS[s].be1;
    rng          = xorshift(rng);
    init1_data_i = rng;
    done   = 1'b0;
    waited = 0;
    while (!done) begin
      @(negedge clk_i);
      g0 = init0_gnt_o;
      g1 = init1_gnt_o;
      // After the first cycle only the losing port is left.
      check_cycle((waited == 0) ? STEPS[s].win : init1_req_i);
      done = !((init0_req_i && !g0) || (init1_req_i && !g1));
      if (!done) begin
        waited++;
        if (waited > GNT_TIMEOUT) begin
          abort_run($sformatf("Step %0d: request not granted within %0d cycles.",
                              s, GNT_TIMEOUT));
        end
        @(posedge clk_i);
        #1;
        // Granted ports drop out; clear is a single pulse.
        if (g0) begin
          init0_req_i = 1'b0;
        end
        if (g1) begin
          init1_req_i = 1'b0;
        end
        clear_i = 1'b0;
      end
    end
  endtask

  initial begin
    clk_i   = 1'b0;
    rst_ni  = 1'b0;
    idle_inputs();
    rng     = 32'h7331;
    exp_rv0 = 1'b0;
    exp_rv1 = 1'b0;
    exp_rd0 = '0;
    exp_rd1 = '0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    // Reset state.
    @(negedge clk_i);
    check_flag("init0_gnt_o", init0_gnt_o, 1'b0);
    check_flag("init1_gnt_o", init1_gnt_o, 1'b0);
    check_flag("init0_r_valid_o", init0_r_valid_o, 1'b0);
    check_flag("init1_r_valid_o", init1_r_valid_o, 1'b0);
    for (int s = 0; s < N_STEPS; s++) begin
      apply_step(s);
    end
    // Let the last response land and check the bus goes quiet.
    repeat (2) begin
      @(posedge clk_i);
      #1;
      idle_inputs();
      @(negedge clk_i);
      check_cycle(1'b0);
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule : tb_tcdm_subsystem

//--- tb.f
common/tcdm_pkg.sv
hdl/tcdm_rr_arbiter.sv
hdl/tcdm_r_id_filter.sv
hdl/tcdm_sram_bank.sv
hdl/tcdm_subsystem.sv
bench/tcdm_protocol_checker.sv
bench/tb_tcdm_subsystem.sv

//--- Makefile
# Verilator build for the TCDM subsystem testbench.
SIM        := verilator
TOP        := tb_tcdm_subsystem
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The binary exits non-zero on $fatal, so make fails with the run.
sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
